// ==== verilog/dcache_consts.svh ====
/*
 Size constants for the data cache subsystem:
 cache index width, SRAM address width and SRAM depth.
*/
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ==================================================
// Data cache
// ==================================================

// Default index width, 4 gives 16 lines.
`define DCACHE_INDEX_BITS 4

// ==================================================
// On-chip SRAM
// ==================================================

// Word address bits; higher address bits alias.
`define SRAM_ADDR_BITS 8
`define SRAM_DEPTH (1 << `SRAM_ADDR_BITS)

`endif

// ==== verilog/dcache_pkg.sv ====
/*
 Shared types: CPU request bundle, Wishbone request/response bundles,
 cache line layout and the controller state enums.
*/
`default_nettype none

package dcache_pkg;

	// CPU side request, held stable until ready.
	typedef struct packed {
		logic rw;
		logic flush;
		logic cacheable;
		logic [31:0] address;
		logic [31:0] wdata;
		logic [3:0] wmask;
	} cpu_req_t;

	// Wishbone classic master outputs.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0] sel;
	} wb_req_t;

	// Wishbone classic slave outputs.
	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// One cache line, tagged with the full word address.
	typedef struct packed {
		logic dirty;
		logic [29:0] tag;
		logic [3:0] mask;
		logic [31:0] data;
	} cache_line_t;

	typedef enum logic [3:0] {
		INITIALIZE,
		IDLE,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE
	} dcache_state_t;

	typedef enum logic {
		FETCH_IDLE,
		FETCH_BUS_WAIT
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== verilog/dcache.sv ====
/*
 Direct-mapped write-back data cache, one word per line with a byte mask.
 Hit check, victim write-back, uncached pass-through, flush and
 self-initialization after reset. Wishbone classic master on the bus side.
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache #(
	parameter int INDEX_BITS = `DCACHE_INDEX_BITS
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire dcache_pkg::cpu_req_t i_req,
	output logic o_ready,
	output logic [31:0] o_rdata,
	output dcache_pkg::wb_req_t o_wb,
	input wire dcache_pkg::wb_rsp_t i_wb
);
	import dcache_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;

	dcache_state_t state;
	logic [INDEX_BITS:0] flush_index;

	// Line array, registered read with write bypass.
	cache_line_t lines [LINES];
	logic [INDEX_BITS-1:0] line_index;
	cache_line_t line_q;

	logic wr_en;
	logic [INDEX_BITS-1:0] wr_index;
	cache_line_t wr_line;

	logic [31:0] line_address;
	logic tag_match;
	logic line_any;
	logic line_full;
	logic [31:0] byte_bits;
	cache_line_t merged_line;
	cache_line_t fresh_line;

	function automatic wb_req_t bus_access(input logic we, input logic [31:0] adr,
			input logic [31:0] dat, input logic [3:0] sel);
		return '{cyc: 1'b1, stb: 1'b1, we: we, adr: {adr[31:2], 2'b00}, dat: dat, sel: sel};
	endfunction

	assign line_address = {line_q.tag, 2'b00};
	assign tag_match = line_q.tag == i_req.address[31:2];
	assign line_any = |line_q.mask;
	assign line_full = &line_q.mask;

	assign byte_bits = {{8{i_req.wmask[3]}}, {8{i_req.wmask[2]}},
		{8{i_req.wmask[1]}}, {8{i_req.wmask[0]}}};
	assign merged_line = '{dirty: 1'b1, tag: i_req.address[31:2],
		mask: line_q.mask | i_req.wmask,
		data: (line_q.data & ~byte_bits) | (i_req.wdata & byte_bits)};
	assign fresh_line = '{dirty: 1'b1, tag: i_req.address[31:2],
		mask: i_req.wmask, data: i_req.wdata};

	// Flush and init walk the array, otherwise follow the CPU address.
	always_comb begin
		if (state inside {INITIALIZE, FLUSH_SETUP, FLUSH_CHECK, FLUSH_WRITE})
			line_index = flush_index[INDEX_BITS-1:0];
		else
			line_index = i_req.address[INDEX_BITS+1:2];
	end

	always_ff @(posedge i_clock) begin
		if (wr_en)
			lines[wr_index] <= wr_line;
		if (wr_en && wr_index == line_index)
			line_q <= wr_line;
		else
			line_q <= lines[line_index];
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			flush_index <= '0;
			o_ready <= 1'b0;
			wr_en <= 1'b0;
			o_wb.cyc <= 1'b0;
			o_wb.stb <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			wr_en <= 1'b0;
			wr_index <= line_index;
			case (state)
				// Hot line check; line_q may still hold the previous index,
				// the tag compare covers that.
				IDLE: begin
					if (i_request && !o_ready) begin
						if (i_req.flush) begin
							flush_index <= '0;
							state <= FLUSH_SETUP;
						end else if (!i_req.cacheable) begin
							o_wb <= bus_access(i_req.rw, i_req.address, i_req.wdata, i_req.wmask);
							state <= PASS_THROUGH;
						end else if (!i_req.rw) begin
							if (line_full && tag_match) begin
								o_rdata <= line_q.data;
								o_ready <= 1'b1;
							end else begin
								state <= READ_SETUP;
							end
						end else if (tag_match) begin
							wr_en <= 1'b1;
							wr_line <= merged_line;
							o_ready <= 1'b1;
						end else begin
							state <= WRITE_SETUP;
						end
					end
				end
				PASS_THROUGH: begin
					if (i_wb.ack) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
						o_rdata <= i_wb.dat;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				// ==================================================
				// Write
				// ==================================================
				WRITE_SETUP: begin
					if (line_any && !tag_match) begin
						o_wb <= bus_access(1'b1, line_address, line_q.data, line_q.mask);
						state <= WRITE_WAIT;
					end else begin
						wr_en <= 1'b1;
						wr_line <= tag_match ? merged_line : fresh_line;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end
				WRITE_WAIT: begin
					if (i_wb.ack) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
						wr_en <= 1'b1;
						wr_line <= fresh_line;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				// ==================================================
				// Read
				// ==================================================
				READ_SETUP: begin
					if (line_full && tag_match) begin
						o_rdata <= line_q.data;
						o_ready <= 1'b1;
						state <= IDLE;
					end else if (line_any && line_q.dirty) begin
						o_wb <= bus_access(1'b1, line_address, line_q.data, line_q.mask);
						state <= READ_WB_WAIT;
					end else begin
						o_wb <= bus_access(1'b0, i_req.address, 32'h0, 4'hf);
						state <= READ_BUS_WAIT;
					end
				end
				READ_WB_WAIT: begin
					if (i_wb.ack) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
						state <= READ_BUS_WAIT;
					end
				end
				READ_BUS_WAIT: begin
					if (i_wb.ack) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
						wr_en <= 1'b1;
						wr_line <= '{dirty: 1'b0, tag: i_req.address[31:2], mask: 4'hf,
							data: i_wb.dat};
						o_rdata <= i_wb.dat;
						o_ready <= 1'b1;
						state <= IDLE;
					end else if (!o_wb.cyc) begin
						// Refill starts after the write-back cycle closed.
						o_wb <= bus_access(1'b0, i_req.address, 32'h0, 4'hf);
					end
				end

				// ==================================================
				// Flush and initialize
				// ==================================================
				FLUSH_SETUP: begin
					if (!flush_index[INDEX_BITS]) begin
						state <= FLUSH_CHECK;
					end else begin
						flush_index <= '0;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end
				FLUSH_CHECK: begin
					if (line_any && line_q.dirty) begin
						o_wb <= bus_access(1'b1, line_address, line_q.data, line_q.mask);
						state <= FLUSH_WRITE;
					end else begin
						flush_index <= flush_index + 1'b1;
						state <= FLUSH_SETUP;
					end
				end
				FLUSH_WRITE: begin
					if (i_wb.ack) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
						// Line is clean now.
						wr_en <= 1'b1;
						wr_line <= line_q;
						wr_line.dirty <= 1'b0;
						flush_index <= flush_index + 1'b1;
						state <= FLUSH_SETUP;
					end
				end
				// Empty lines carry their own index as tag, so a stale line_q
				// from another index never matches.
				INITIALIZE: begin
					if (!flush_index[INDEX_BITS]) begin
						wr_en <= 1'b1;
						wr_line <= '{dirty: 1'b0, tag: 30'(flush_index[INDEX_BITS-1:0]),
							mask: 4'h0, data: 32'h0};
						flush_index <= flush_index + 1'b1;
					end else begin
						flush_index <= '0;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		state == INITIALIZE |-> !o_ready);

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb.stb |-> o_wb.cyc);

endmodule

`default_nettype wire

// ==== verilog/fetch_port.sv ====
/*
 Read-only instruction fetch master with a one-word tagged buffer.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire [31:0] i_address,
	input wire i_invalidate,
	output logic o_ready,
	output logic [31:0] o_data,
	output dcache_pkg::wb_req_t o_wb,
	input wire dcache_pkg::wb_rsp_t i_wb
);
	import dcache_pkg::*;

	fetch_state_t state;

	logic buf_valid;
	logic [29:0] buf_tag;
	logic [31:0] buf_data;
	logic buf_hit;

	assign buf_hit = buf_valid && buf_tag == i_address[31:2];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH_IDLE;
			o_ready <= 1'b0;
			buf_valid <= 1'b0;
			o_wb.cyc <= 1'b0;
			o_wb.stb <= 1'b0;
			o_wb.we <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				FETCH_IDLE: begin
					if (i_request && !o_ready) begin
						if (buf_hit) begin
							o_data <= buf_data;
							o_ready <= 1'b1;
						end else begin
							o_wb <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0,
								adr: {i_address[31:2], 2'b00}, dat: 32'h0, sel: 4'hf};
							state <= FETCH_BUS_WAIT;
						end
					end
				end
				FETCH_BUS_WAIT: begin
					if (i_wb.ack) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
						buf_valid <= 1'b1;
						buf_tag <= i_address[31:2];
						buf_data <= i_wb.dat;
						o_data <= i_wb.dat;
						o_ready <= 1'b1;
						state <= FETCH_IDLE;
					end
				end
				default: begin
					state <= FETCH_IDLE;
				end
			endcase
			// Invalidate wins over a refill in the same cycle.
			if (i_invalidate)
				buf_valid <= 1'b0;
		end
	end

	// Fetches are always full-word reads.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb.cyc |-> !o_wb.we && o_wb.sel == 4'hf);

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
/*
 Round-robin arbiter for two Wishbone classic masters onto one slave.
 Grant is held for the whole cycle of the granted master.
*/
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
	input wire i_clock,
	input wire i_reset,
	input wire dcache_pkg::wb_req_t i_m0_req,
	input wire dcache_pkg::wb_req_t i_m1_req,
	output dcache_pkg::wb_rsp_t o_m0_rsp,
	output dcache_pkg::wb_rsp_t o_m1_rsp,
	output dcache_pkg::wb_req_t o_s_req,
	input wire dcache_pkg::wb_rsp_t i_s_rsp
);

	logic grant_q;
	logic last_q;
	logic busy;
	logic grant;

	// Bus is owned while the granted master keeps cyc high.
	assign busy = grant_q ? i_m1_req.cyc : i_m0_req.cyc;

	// New grant takes effect in the same cycle, no added latency.
	always_comb begin
		if (busy)
			grant = grant_q;
		else if (i_m0_req.cyc && i_m1_req.cyc)
			grant = !last_q;
		else
			grant = i_m1_req.cyc;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			grant_q <= 1'b0;
			// m0 wins the first conflict.
			last_q <= 1'b1;
		end else begin
			grant_q <= grant;
			if (!busy && (i_m0_req.cyc || i_m1_req.cyc))
				last_q <= grant;
		end
	end

	assign o_s_req = grant ? i_m1_req : i_m0_req;
	assign o_m0_rsp = '{ack: i_s_rsp.ack && !grant, dat: i_s_rsp.dat};
	assign o_m1_rsp = '{ack: i_s_rsp.ack && grant, dat: i_s_rsp.dat};

	// An ack goes back to the master whose strobe the slave took.
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_s_rsp.ack |-> $past(o_s_req.cyc && o_s_req.stb) && grant == $past(grant));

endmodule

`default_nettype wire

// ==== verilog/wb_sram.sv ====
/*
 Single-port Wishbone classic SRAM slave.
 Byte-lane writes under sel, registered read data and ack.
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module wb_sram (
	input wire i_clock,
	input wire i_reset,
	input wire dcache_pkg::wb_req_t i_wb,
	output dcache_pkg::wb_rsp_t o_wb
);

	logic [31:0] mem [`SRAM_DEPTH];
	logic [`SRAM_ADDR_BITS-1:0] word_index;
	logic access;
	logic ack_q;
	logic [31:0] rdata_q;

	// Upper address bits are dropped, so addresses alias.
	assign word_index = i_wb.adr[`SRAM_ADDR_BITS+1:2];

	// One access per strobe; the ack cycle itself is not sampled again.
	assign access = i_wb.cyc && i_wb.stb && !ack_q;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_wb.we) begin
				for (int b = 0; b < 4; b++) begin
					if (i_wb.sel[b])
						mem[word_index][8*b +: 8] <= i_wb.dat[8*b +: 8];
				end
			end
			rdata_q <= mem[word_index];
		end
	end

	assign o_wb = '{ack: ack_q, dat: rdata_q};

endmodule

`default_nettype wire

// ==== verilog/dcache_subsystem.sv ====
/*
 Memory subsystem top: data cache and fetch port sharing one SRAM
 through the Wishbone arbiter.
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem (
	input wire i_clock,
	input wire i_reset,
	input wire i_data_request,
	input wire dcache_pkg::cpu_req_t i_data_req,
	output logic o_data_ready,
	output logic [31:0] o_data_rdata,
	input wire i_fetch_request,
	input wire [31:0] i_fetch_address,
	input wire i_fetch_invalidate,
	output logic o_fetch_ready,
	output logic [31:0] o_fetch_data
);
	import dcache_pkg::*;

	wb_req_t cache_wb_req;
	wb_rsp_t cache_wb_rsp;
	wb_req_t fetch_wb_req;
	wb_rsp_t fetch_wb_rsp;
	wb_req_t sram_req;
	wb_rsp_t sram_rsp;

	dcache u_dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_data_request),
		.i_req(i_data_req),
		.o_ready(o_data_ready),
		.o_rdata(o_data_rdata),
		.o_wb(cache_wb_req),
		.i_wb(cache_wb_rsp)
	);

	fetch_port u_fetch_port (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_fetch_request),
		.i_address(i_fetch_address),
		.i_invalidate(i_fetch_invalidate),
		.o_ready(o_fetch_ready),
		.o_data(o_fetch_data),
		.o_wb(fetch_wb_req),
		.i_wb(fetch_wb_rsp)
	);

	// Cache on m0, fetch on m1.
	wb_arbiter u_wb_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_m0_req(cache_wb_req),
		.i_m1_req(fetch_wb_req),
		.o_m0_rsp(cache_wb_rsp),
		.o_m1_rsp(fetch_wb_rsp),
		.o_s_req(sram_req),
		.i_s_rsp(sram_rsp)
	);

	wb_sram u_wb_sram (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb(sram_req),
		.o_wb(sram_rsp)
	);

endmodule

`default_nettype wire

// ==== tb/tb_dcache_subsystem.sv ====
/*
 Directed testbench for the data cache subsystem.
 Shadow SRAM and cache models, LFSR stimulus, compare tasks and watchdog.
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tb_dcache_subsystem;
	import dcache_pkg::*;

	localparam int LINES = 1 << `DCACHE_INDEX_BITS;
	// Requests, fetches and invalidates issued over all tests, rounded up.
	localparam int TOTAL_OPS = 160;
	localparam int WATCHDOG_CYCLES = TOTAL_OPS * LINES * 8;

	logic i_clock;
	logic i_reset;
	logic i_data_request;
	cpu_req_t i_data_req;
	logic o_data_ready;
	logic [31:0] o_data_rdata;
	logic i_fetch_request;
	logic [31:0] i_fetch_address;
	logic i_fetch_invalidate;
	logic o_fetch_ready;
	logic [31:0] o_fetch_data;

	int error_count;
	int check_count;
	int test_count;
	logic [15:0] lfsr_q;

	// Models of the SRAM contents and of the cache lines.
	logic [31:0] shadow_sram [`SRAM_DEPTH];
	cache_line_t model_line [LINES];

	dcache_subsystem i_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data_request(i_data_request),
		.i_data_req(i_data_req),
		.o_data_ready(o_data_ready),
		.o_data_rdata(o_data_rdata),
		.i_fetch_request(i_fetch_request),
		.i_fetch_address(i_fetch_address),
		.i_fetch_invalidate(i_fetch_invalidate),
		.o_fetch_ready(o_fetch_ready),
		.o_fetch_data(o_fetch_data)
	);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		$display("Watchdog expired: no completion within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int b = 0; b < count; b++) begin
			value = {value[30:0], lfsr_q[15]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_data,
			input logic [31:0] new_data, input logic [3:0] mask);
		logic [31:0] result;
		result = old_data;
		for (int b = 0; b < 4; b++) begin
			if (mask[b])
				result[8*b +: 8] = new_data[8*b +: 8];
		end
		return result;
	endfunction

	task automatic check_word(input string name, input logic [31:0] address,
			input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %s at 0x%08h: expected 0x%08h, got 0x%08h",
				name, address, expected, actual);
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		test_count++;
		if (error_count == start_errors)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, error_count - start_errors);
	endtask

	// Called and returning 1 ns after a rising edge.
	task automatic data_access(input cpu_req_t req, output logic [31:0] rdata);
		i_data_req = req;
		i_data_request = 1'b1;
		do begin
			@(posedge i_clock);
			#1;
		end while (!o_data_ready);
		rdata = o_data_rdata;
		i_data_request = 1'b0;
		@(posedge i_clock);
		#1;
	endtask

	task automatic fetch_word(input logic [31:0] address, output logic [31:0] data);
		i_fetch_address = address;
		i_fetch_request = 1'b1;
		do begin
			@(posedge i_clock);
			#1;
		end while (!o_fetch_ready);
		data = o_fetch_data;
		i_fetch_request = 1'b0;
		@(posedge i_clock);
		#1;
	endtask

	task automatic invalidate_fetch();
		i_fetch_invalidate = 1'b1;
		@(posedge i_clock);
		#1;
		i_fetch_invalidate = 1'b0;
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	task automatic shadow_write(input logic [31:0] address, input logic [31:0] data,
			input logic [3:0] mask);
		logic [`SRAM_ADDR_BITS-1:0] word;
		word = address[`SRAM_ADDR_BITS+1:2];
		shadow_sram[word] = merge_bytes(shadow_sram[word], data, mask);
	endtask

	// A victim goes out under its own byte mask.
	task automatic model_write_back(input int idx);
		shadow_write({model_line[idx].tag, 2'b00}, model_line[idx].data, model_line[idx].mask);
	endtask

	task automatic model_cached_write(input logic [31:0] address, input logic [31:0] data,
			input logic [3:0] mask);
		int idx;
		idx = address[`DCACHE_INDEX_BITS+1:2];
		if (model_line[idx].tag == address[31:2]) begin
			model_line[idx].data = merge_bytes(model_line[idx].data, data, mask);
			model_line[idx].mask = model_line[idx].mask | mask;
			model_line[idx].dirty = 1'b1;
		end else begin
			// Any valid victim is written back, clean or not.
			if (|model_line[idx].mask)
				model_write_back(idx);
			model_line[idx].dirty = 1'b1;
			model_line[idx].tag = address[31:2];
			model_line[idx].mask = mask;
			model_line[idx].data = data;
		end
	endtask

	task automatic model_cached_read(input logic [31:0] address, output logic [31:0] value);
		int idx;
		idx = address[`DCACHE_INDEX_BITS+1:2];
		if (model_line[idx].tag == address[31:2] && &model_line[idx].mask) begin
			value = model_line[idx].data;
		end else begin
			if (|model_line[idx].mask && model_line[idx].dirty)
				model_write_back(idx);
			value = shadow_sram[address[`SRAM_ADDR_BITS+1:2]];
			model_line[idx].dirty = 1'b0;
			model_line[idx].tag = address[31:2];
			model_line[idx].mask = 4'hf;
			model_line[idx].data = value;
		end
	endtask

	// ==================================================
	// Operations with checks
	// ==================================================

	task automatic write_word(input logic [31:0] address, input logic [31:0] data,
			input logic [3:0] mask, input logic cacheable);
		cpu_req_t req;
		logic [31:0] unused;
		req = '0;
		req.rw = 1'b1;
		req.cacheable = cacheable;
		req.address = address;
		req.wdata = data;
		req.wmask = mask;
		data_access(req, unused);
		if (cacheable)
			model_cached_write(address, data, mask);
		else
			shadow_write(address, data, mask);
	endtask

	task automatic read_word(input logic [31:0] address, input logic cacheable);
		cpu_req_t req;
		logic [31:0] got;
		logic [31:0] expected;
		req = '0;
		req.cacheable = cacheable;
		req.address = address;
		req.wmask = 4'hf;
		data_access(req, got);
		if (cacheable)
			model_cached_read(address, expected);
		else
			expected = shadow_sram[address[`SRAM_ADDR_BITS+1:2]];
		check_word("o_data_rdata", address, expected, got);
	endtask

	task automatic flush_cache();
		cpu_req_t req;
		logic [31:0] unused;
		req = '0;
		req.flush = 1'b1;
		data_access(req, unused);
		for (int i = 0; i < LINES; i++) begin
			if (|model_line[i].mask && model_line[i].dirty) begin
				model_write_back(i);
				model_line[i].dirty = 1'b0;
			end
		end
	endtask

	task automatic fetch_check(input logic [31:0] address);
		logic [31:0] got;
		invalidate_fetch();
		fetch_word(address, got);
		check_word("o_fetch_data", address, shadow_sram[address[`SRAM_ADDR_BITS+1:2]], got);
	endtask

	// ==================================================
	// Tests
	// ==================================================

	task automatic test_uncached();
		int start_errors;
		logic [31:0] got;
		logic [31:0] buffered;
		start_errors = error_count;
		write_word(32'h040, 32'h1234_5678, 4'hf, 1'b0);
		read_word(32'h040, 1'b0);
		fetch_check(32'h040);
		// The fetch buffer keeps the old word until it is invalidated.
		buffered = shadow_sram[32'h040 >> 2];
		write_word(32'h040, 32'h8765_4321, 4'hf, 1'b0);
		fetch_word(32'h040, got);
		check_word("o_fetch_data", 32'h040, buffered, got);
		fetch_check(32'h040);
		report_test("uncached", start_errors);
	endtask

	task automatic test_partial_writes();
		int start_errors;
		start_errors = error_count;
		write_word(32'h084, 32'haaaa_5555, 4'hf, 1'b0);
		write_word(32'h084, 32'h1111_1111, 4'h1, 1'b1);
		write_word(32'h084, 32'h2222_2222, 4'h2, 1'b1);
		write_word(32'h084, 32'h3333_3333, 4'hc, 1'b1);
		read_word(32'h084, 1'b1);
		write_word(32'h084, 32'hdead_beef, 4'hf, 1'b1);
		read_word(32'h084, 1'b1);
		// Write-back cache, so the SRAM still has the old word.
		fetch_check(32'h084);
		report_test("partial_writes", start_errors);
	endtask

	task automatic test_eviction();
		int start_errors;
		start_errors = error_count;
		write_word(32'h0c8, 32'hc0ff_ee01, 4'hf, 1'b1);
		write_word(32'h0c8 + 4 * LINES, 32'h0bad_f00d, 4'hf, 1'b1);
		fetch_check(32'h0c8);
		read_word(32'h0c8, 1'b1);
		report_test("eviction", start_errors);
	endtask

	task automatic test_flush();
		int start_errors;
		start_errors = error_count;
		for (int i = 0; i < 5; i++)
			write_word(32'h1c0 + 4 * i, 32'h4000_0000 + i * 32'h0101_0101, 4'hf, 1'b1);
		flush_cache();
		for (int i = 0; i < 5; i++)
			fetch_check(32'h1c0 + 4 * i);
		report_test("flush", start_errors);
	endtask

	task automatic test_concurrent();
		int start_errors;
		logic [31:0] got;
		start_errors = error_count;
		write_word(32'h200, 32'h5a5a_0001, 4'hf, 1'b0);
		write_word(32'h244, 32'ha5a5_0002, 4'hf, 1'b0);
		invalidate_fetch();
		fork
			read_word(32'h200, 1'b1);
			begin
				fetch_word(32'h244, got);
				check_word("o_fetch_data", 32'h244, shadow_sram[32'h244 >> 2], got);
			end
		join
		report_test("concurrent", start_errors);
	endtask

	task automatic test_random_mix();
		int start_errors;
		logic [31:0] cacheable;
		logic [31:0] rw;
		logic [31:0] pick;
		logic [31:0] mask;
		logic [31:0] data;
		logic [31:0] address;
		start_errors = error_count;
		// Two tags on each of indices 0 to 3.
		for (int i = 0; i < 8; i++)
			write_word(32'h100 + 4 * (i % 4) + 4 * LINES * (i / 4), 32'h7700_0000 + i, 4'hf, 1'b0);
		for (int n = 0; n < 64; n++) begin
			random_bits(1, cacheable);
			random_bits(1, rw);
			random_bits(3, pick);
			address = 32'h100 + 4 * pick[1:0] + 4 * LINES * pick[2];
			if (rw[0]) begin
				random_bits(4, mask);
				random_bits(32, data);
				if (mask[3:0] == 4'h0)
					mask = 32'hf;
				write_word(address, data, mask[3:0], cacheable[0]);
			end else begin
				read_word(address, cacheable[0]);
			end
		end
		flush_cache();
		for (int i = 0; i < 8; i++)
			fetch_check(32'h100 + 4 * (i % 4) + 4 * LINES * (i / 4));
		report_test("random_mix", start_errors);
	endtask

	initial begin
		i_reset = 1'b1;
		i_data_request = 1'b0;
		i_data_req = '0;
		i_fetch_request = 1'b0;
		i_fetch_address = '0;
		i_fetch_invalidate = 1'b0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		lfsr_q = 16'd14;
		for (int i = 0; i < `SRAM_DEPTH; i++)
			shadow_sram[i] = '0;
		// Empty lines carry their own index as tag.
		for (int i = 0; i < LINES; i++) begin
			model_line[i].dirty = 1'b0;
			model_line[i].tag = 30'(i);
			model_line[i].mask = 4'h0;
			model_line[i].data = '0;
		end
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;

		test_uncached();
		test_partial_writes();
		test_eviction();
		test_flush();
		test_concurrent();
		test_random_mix();

		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache.sv
verilog/fetch_port.sv
verilog/wb_arbiter.sv
verilog/wb_sram.sv
verilog/dcache_subsystem.sv
tb/tb_dcache_subsystem.sv

// ==== Bender.yml ====
package:
  name: dcache_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/dcache.sv
      - verilog/fetch_port.sv
      - verilog/wb_arbiter.sv
      - verilog/wb_sram.sv
      - verilog/dcache_subsystem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_dcache_subsystem.sv
